/* src.f */
source/spisreg_pkg.sv
source/buf_if.sv
source/levelsync.sv
source/spis_fifo.sv
source/spis_reg.sv
source/flush_ctrl.sv
source/xfer_timer.sv
source/spisreg_top.sv
testbench/tb_spisreg_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_spisreg_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_spisreg_top.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the spi slave register block
// stimulus table applied in a loop, model queues for both buffers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_spisreg_top
	import spisreg_pkg::*;
();

	typedef enum logic [2:0] {SPI_WR, SPI_RD, AVB_WR, AVB_RD, SSN, VLD_UP, TMO} op_t;

	typedef struct packed {
		op_t        op;
		addr_t      addr;
		data_t      data;
		data_t      exp;
		logic [3:0] id;	// test number
	} entry_t;

	logic        s_avmm_clk;
	logic        s_avmm_rst_n;
	logic        spi_write;
	logic        spi_read;
	logic        ssn_off;
	addr_t       spi_wr_addr;
	addr_t       spi_rd_addr;
	data_t       mosi_data;
	data_t       miso_data;
	logic        avb2reg_write;
	logic        avb2reg_read;
	addr_t       avb2reg_addr;
	data_t       avb2reg_rdata;
	data_t       reg2avb_wdata;
	data_t       dbg_bus0;
	data_t       dbg_bus1;
	logic        avmmtransvld_up;
	logic [7:0]  avmm_brstlen;
	logic [1:0]  avmm_sel;
	logic [16:0] avmm_offset;
	logic        avmm_rdnwr;
	logic        avmm_transvld;
	logic        avmm_active;

	entry_t stim [$];
	data_t  wq [$];	// words expected out of the write buffer
	data_t  rq [$];	// and out of the read buffer
	data_t  last_wdata;
	int     checks;
	int     errors;
	int     test_chk [1:5];
	int     test_err [1:5];
	logic   timed_out;
	int     cyc;	// rising edges since time zero
	int     load_cyc;	// edge of the last s_cmd load

	spisreg_top UUT (.*);

	initial begin
		s_avmm_clk = 1'b0;
		forever #10 s_avmm_clk = ~s_avmm_clk;
	end

	always @(posedge s_avmm_clk)
		cyc <= cyc + 1;

	function automatic logic in_range(input addr_t a, input addr_t lo, input addr_t hi);
		return (a >= lo) && (a <= hi);
	endfunction

	function automatic data_t make_cmd(input logic rdnwr);
		data_t c;
		c = '0;
		c[CMD_BRST_HI:CMD_BRST_LO] = 8'($urandom);
		c[CMD_SEL_HI:CMD_SEL_LO]   = 2'($urandom);
		c[CMD_OFS_HI:CMD_OFS_LO]   = 17'($urandom);
		c[CMD_RDNWR]               = rdnwr;
		c[CMD_TRANSVLD]            = 1'b1;
		return c;
	endfunction

	task automatic add_entry(input op_t op, input addr_t addr, input data_t data,
		input data_t exp, input int id);
		entry_t e;
		e.op   = op;
		e.addr = addr;
		e.data = data;
		e.exp  = exp;
		e.id   = 4'(id);
		stim.push_back(e);
	endtask

	task automatic check_word(input string what, input data_t got, input data_t exp,
		input int id);
		checks++;
		test_chk[id]++;
		if (got !== exp) begin
			errors++;
			test_err[id]++;
			$display("mismatch at %0t: test %0d %s is %h, expected %h",
				$time, id, what, got, exp);
		end
	endtask

	// drop the spi level after four high cycles, then four low
	task automatic strobe_tail();
		@(posedge s_avmm_clk);
		spi_write <= 1'b0;
		spi_read  <= 1'b0;
		ssn_off   <= 1'b0;
		repeat (4) @(posedge s_avmm_clk);
	endtask

	task automatic build_stim();
		data_t cmd_wr;
		data_t cmd_rd;
		data_t dbg0;
		data_t dbg1;
		// 1: write buffer round trip
		for (int k = 0; k < 10; k++)
			add_entry(SPI_WR, WBUF_LO + addr_t'(4 * k), $urandom, '0, 1);
		add_entry(SPI_RD, REG_STATUS, '0, 32'd10 << ST_WCNT_LO, 1);
		for (int k = 0; k < 10; k++)
			add_entry(AVB_RD, WBUF_LO, '0, '0, 1);
		// 2: read buffer round trip, unmapped read
		for (int k = 0; k < 8; k++)
			add_entry(AVB_WR, RBUF_LO + addr_t'(4 * k), $urandom, '0, 2);
		for (int k = 0; k < 8; k++)
			add_entry(SPI_RD, RBUF_LO, '0, '0, 2);
		add_entry(SPI_RD, 16'h0100, '0, '0, 2);
		// 3: write command, completed by avmmtransvld_up
		cmd_wr = make_cmd(1'b0);
		dbg1   = $urandom;
		add_entry(SPI_WR, REG_CMD, cmd_wr, '0, 3);
		add_entry(VLD_UP, '0, dbg1, '0, 3);
		add_entry(SPI_RD, REG_DIAG1, '0, dbg1, 3);
		add_entry(SPI_RD, REG_CMD, '0, cmd_wr & ~(32'h1 << CMD_TRANSVLD), 3);
		// 4: read command that never completes
		cmd_rd = make_cmd(1'b1);
		add_entry(SPI_WR, REG_CMD, cmd_rd, '0, 4);
		add_entry(TMO, '0, '0, '0, 4);
		add_entry(SPI_RD, REG_STATUS, '0, 32'h1 << ST_TIMEOUT, 4);
		// 5: underflow, then flush of the read buffer on ssn_off
		cmd_rd = make_cmd(1'b1);
		dbg0   = $urandom;
		add_entry(AVB_RD, WBUF_LO, '0, '0, 5);
		add_entry(SPI_RD, REG_STATUS, '0, (32'h1 << ST_TIMEOUT) | (32'h1 << ST_WUDF), 5);
		add_entry(SPI_WR, REG_CMD, cmd_rd, '0, 5);
		for (int k = 0; k < 3; k++)
			add_entry(AVB_WR, RBUF_LO, $urandom, '0, 5);
		add_entry(SPI_RD, REG_STATUS, '0,
			(32'h1 << ST_TIMEOUT) | (32'h1 << ST_WUDF) | (32'd3 << ST_RCNT_LO), 5);
		add_entry(SSN, '0, dbg0, '0, 5);
		add_entry(SPI_RD, REG_STATUS, '0, (32'h1 << ST_TIMEOUT) | (32'h1 << ST_WUDF), 5);
		add_entry(SPI_RD, REG_DIAG0, '0, dbg0, 5);
	endtask

	task automatic apply_entry(input entry_t e);
		data_t exp;
		int    waited;
		exp = e.exp;
		case (e.op)
			SPI_WR: begin
				@(posedge s_avmm_clk);
				spi_wr_addr <= e.addr;
				mosi_data   <= e.data;
				spi_write   <= 1'b1;
				repeat (3) @(posedge s_avmm_clk);	// two sync flops, then the access
				@(negedge s_avmm_clk);
				if (in_range(e.addr, WBUF_LO, WBUF_HI))
					wq.push_back(e.data);
				if (e.addr == REG_CMD) begin
					load_cyc = cyc;
					@(negedge s_avmm_clk);	// pins follow one cycle after the load
					check_word("avmm_brstlen", 32'(avmm_brstlen),
						32'(e.data[CMD_BRST_HI:CMD_BRST_LO]), e.id);
					check_word("avmm_sel", 32'(avmm_sel), 32'(e.data[CMD_SEL_HI:CMD_SEL_LO]), e.id);
					check_word("avmm_offset", 32'(avmm_offset),
						32'(e.data[CMD_OFS_HI:CMD_OFS_LO]), e.id);
					check_word("avmm_rdnwr", 32'(avmm_rdnwr), 32'(e.data[CMD_RDNWR]), e.id);
					check_word("avmm_active", 32'(avmm_active), 32'd1, e.id);
				end
				strobe_tail();
			end
			SPI_RD: begin
				@(posedge s_avmm_clk);
				spi_rd_addr <= e.addr;
				spi_read    <= 1'b1;
				repeat (3) @(posedge s_avmm_clk);
				@(negedge s_avmm_clk);
				if (in_range(e.addr, RBUF_LO, RBUF_HI) && rq.size() != 0)
					exp = rq.pop_front();
				check_word("miso_data", miso_data, exp, e.id);
				strobe_tail();
			end
			AVB_WR: begin
				@(posedge s_avmm_clk);
				avb2reg_addr  <= e.addr;
				avb2reg_rdata <= e.data;
				avb2reg_write <= 1'b1;
				@(posedge s_avmm_clk);
				avb2reg_write <= 1'b0;
				if (in_range(e.addr, RBUF_LO, RBUF_HI))
					rq.push_back(e.data);
			end
			AVB_RD: begin
				@(posedge s_avmm_clk);
				avb2reg_addr <= e.addr;
				avb2reg_read <= 1'b1;
				@(posedge s_avmm_clk);
				avb2reg_read <= 1'b0;
				@(negedge s_avmm_clk);
				// an empty buffer leaves the last word in place
				if (in_range(e.addr, WBUF_LO, WBUF_HI) && wq.size() != 0)
					last_wdata = wq.pop_front();
				check_word("reg2avb_wdata", reg2avb_wdata, last_wdata, e.id);
			end
			SSN: begin
				@(posedge s_avmm_clk);
				dbg_bus0 <= e.data;
				ssn_off  <= 1'b1;
				repeat (3) @(posedge s_avmm_clk);
				wq.delete();	// end of a read command flushes both buffers
				rq.delete();
				strobe_tail();
			end
			VLD_UP: begin
				@(posedge s_avmm_clk);
				dbg_bus1        <= e.data;
				avmmtransvld_up <= 1'b1;
				@(posedge s_avmm_clk);
				avmmtransvld_up <= 1'b0;
				@(negedge s_avmm_clk);
				check_word("avmm_transvld", 32'(avmm_transvld), 32'd0, e.id);
				check_word("avmm_active", 32'(avmm_active), 32'd0, e.id);
			end
			TMO: begin
				waited = 0;
				@(negedge s_avmm_clk);
				while (avmm_transvld && waited < CMD_TIMEOUT + 32) begin
					@(negedge s_avmm_clk);
					waited++;
				end
				if (avmm_transvld) begin
					$display("timeout: watchdog never dropped avmm_transvld in test %0d", e.id);
					timed_out = 1'b1;
				end else begin
					// fires CMD_TIMEOUT cycles after the load, transvld drops one edge later
					check_word("watchdog cycles from load", 32'(cyc - load_cyc),
						32'(CMD_TIMEOUT + 1), e.id);
					check_word("avmm_active", 32'(avmm_active), 32'd0, e.id);
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		void'($urandom(57));
		s_avmm_rst_n    = 1'b0;
		spi_write       = 1'b0;
		spi_read        = 1'b0;
		ssn_off         = 1'b0;
		spi_wr_addr     = '0;
		spi_rd_addr     = '0;
		mosi_data       = '0;
		avb2reg_write   = 1'b0;
		avb2reg_read    = 1'b0;
		avb2reg_addr    = '0;
		avb2reg_rdata   = '0;
		dbg_bus0        = '0;
		dbg_bus1        = '0;
		avmmtransvld_up = 1'b0;
		last_wdata      = '0;
		load_cyc        = 0;
		checks          = 0;
		errors          = 0;
		timed_out       = 1'b0;
		for (int t = 1; t <= 5; t++) begin
			test_chk[t] = 0;
			test_err[t] = 0;
		end
		build_stim();
		repeat (16) @(posedge s_avmm_clk);
		s_avmm_rst_n <= 1'b1;

		for (int i = 0; i < stim.size() && !timed_out; i++) begin
			apply_entry(stim[i]);
			if (i == stim.size() - 1 || stim[i + 1].id != stim[i].id)
				$display("test %0d finished, %0d checks, %0d errors",
					stim[i].id, test_chk[stim[i].id], test_err[stim[i].id]);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* source/spisreg_top.sv */
////////////////////////////////////////////////////////////////////////////
// spi slave register block top
// strobe sync, address decode, write/read buffers, registers, flush, watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spisreg_top
	import spisreg_pkg::*;
(
	input  logic        s_avmm_clk,
	input  logic        s_avmm_rst_n,
	// spi side, levels from the shifter domain
	input  logic        spi_write,
	input  logic        spi_read,
	input  logic        ssn_off,
	input  addr_t       spi_wr_addr,
	input  addr_t       spi_rd_addr,
	input  data_t       mosi_data,
	output data_t       miso_data,
	// avmm side
	input  logic        avb2reg_write,
	input  logic        avb2reg_read,
	input  addr_t       avb2reg_addr,
	input  data_t       avb2reg_rdata,
	output data_t       reg2avb_wdata,
	input  data_t       dbg_bus0,
	input  data_t       dbg_bus1,
	input  logic        avmmtransvld_up,
	output logic [7:0]  avmm_brstlen,
	output logic [1:0]  avmm_sel,
	output logic [16:0] avmm_offset,
	output logic        avmm_rdnwr,
	output logic        avmm_transvld,
	output logic        avmm_active
);

	logic  spi_wr_rise;
	logic  spi_rd_rise;
	logic  ssn_off_rise;
	logic  spi_wr_wbuf;
	logic  spi_rd_rbuf;
	logic  avb_wbuf;
	logic  avb_rbuf;
	addr_t reg_addr;
	data_t reg_rdata;
	data_t s_cmd;
	data_t miso_buf;
	logic  miso_from_reg;	// miso shows the register read, else the buffer word
	logic  xfer_timeout;

	buf_if #(.payload_t(data_t)) wbuf_if ();
	buf_if #(.payload_t(data_t)) rbuf_if ();

	function automatic logic in_window(addr_t a, addr_t lo, addr_t hi);
		return (a >= lo) && (a <= hi);
	endfunction

	levelsync u_sync_wr  (.s_avmm_clk, .s_avmm_rst_n, .level(spi_write),
		.synced(), .rise(spi_wr_rise));
	levelsync u_sync_rd  (.s_avmm_clk, .s_avmm_rst_n, .level(spi_read),
		.synced(), .rise(spi_rd_rise));
	levelsync u_sync_ssn (.s_avmm_clk, .s_avmm_rst_n, .level(ssn_off),
		.synced(), .rise(ssn_off_rise));

	//////////////////////////////////////////////////////////////////////////
	// address decode and buffer push/pop
	//////////////////////////////////////////////////////////////////////////
	assign spi_wr_wbuf = in_window(spi_wr_addr, WBUF_LO, WBUF_HI);
	assign spi_rd_rbuf = in_window(spi_rd_addr, RBUF_LO, RBUF_HI);
	assign avb_wbuf    = in_window(avb2reg_addr, WBUF_LO, WBUF_HI);
	assign avb_rbuf    = in_window(avb2reg_addr, RBUF_LO, RBUF_HI);

	assign wbuf_if.push   = spi_wr_rise & spi_wr_wbuf;	// spi master fills
	assign wbuf_if.wrdata = mosi_data;
	assign wbuf_if.pop    = avb2reg_read & avb_wbuf;	// avmm drains
	assign rbuf_if.push   = avb2reg_write & avb_rbuf;
	assign rbuf_if.wrdata = avb2reg_rdata;
	assign rbuf_if.pop    = spi_rd_rise & spi_rd_rbuf;

	// a read in the same cycle as a write takes the address
	assign reg_addr = spi_rd_rise ? spi_rd_addr : spi_wr_addr;

	spis_fifo #(.payload_t(data_t), .DEPTH(BUF_DEPTH)) u_wbuf (
		.s_avmm_clk, .s_avmm_rst_n, .bus(wbuf_if));
	spis_fifo #(.payload_t(data_t), .DEPTH(BUF_DEPTH)) u_rbuf (
		.s_avmm_clk, .s_avmm_rst_n, .bus(rbuf_if));

	spis_reg u_reg (
		.s_avmm_clk, .s_avmm_rst_n,
		.wr              (spi_wr_rise),
		.rd              (spi_rd_rise & ~spi_rd_rbuf),
		.addr            (reg_addr),
		.wdata           (mosi_data),
		.rdata           (reg_rdata),
		.avmmtransvld_up,
		.timeout         (xfer_timeout),
		.ssn_off         (ssn_off_rise),
		.dbg_bus0, .dbg_bus1,
		.wbuf            (wbuf_if),
		.rbuf            (rbuf_if),
		.s_cmd
	);

	flush_ctrl u_flush (
		.s_avmm_clk, .s_avmm_rst_n, .s_cmd, .avmmtransvld_up,
		.ssn_off    (ssn_off_rise),
		.wbuf       (wbuf_if),
		.rbuf       (rbuf_if),
		.wbuf_flush (wbuf_if.flush),
		.rbuf_flush (rbuf_if.flush)
	);

	xfer_timer u_timer (.s_avmm_clk, .s_avmm_rst_n, .run(s_cmd[CMD_TRANSVLD]),
		.done(avmmtransvld_up), .timeout(xfer_timeout));

	//////////////////////////////////////////////////////////////////////////
	// output registers, a pop of an empty buffer leaves them unchanged
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			miso_from_reg <= 1'b1;
		else if (spi_rd_rise && !spi_rd_rbuf)
			miso_from_reg <= 1'b1;
		else if (rbuf_if.pop && !rbuf_if.empty)
			miso_from_reg <= 1'b0;
	end

	always_ff @(posedge s_avmm_clk) begin
		if (rbuf_if.pop && !rbuf_if.empty)
			miso_buf <= rbuf_if.rddata;
	end

	assign miso_data = miso_from_reg ? reg_rdata : miso_buf;

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			reg2avb_wdata <= '0;
		else if (wbuf_if.pop && !wbuf_if.empty)
			reg2avb_wdata <= wbuf_if.rddata;
	end

	// s_cmd field split
	assign avmm_brstlen  = s_cmd[CMD_BRST_HI:CMD_BRST_LO];
	assign avmm_sel      = s_cmd[CMD_SEL_HI:CMD_SEL_LO];
	assign avmm_offset   = s_cmd[CMD_OFS_HI:CMD_OFS_LO];
	assign avmm_rdnwr    = s_cmd[CMD_RDNWR];
	assign avmm_transvld = s_cmd[CMD_TRANSVLD];
	assign avmm_active   = avmm_transvld;

endmodule

/* source/xfer_timer.sv */
////////////////////////////////////////////////////////////////////////////
// watchdog for an avmm transaction that never completes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xfer_timer
	import spisreg_pkg::*;
(
	input  logic s_avmm_clk,
	input  logic s_avmm_rst_n,
	input  logic run,
	input  logic done,
	output logic timeout
);

	logic [TMR_W-1:0] cnt;
	logic             counting;

	assign counting = run & ~done;

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			cnt     <= '0;
			timeout <= 1'b0;
		end else begin
			timeout <= counting && (cnt == TMR_W'(CMD_TIMEOUT - 1));	// single pulse
			if (!counting)
				cnt <= '0;
			else if (cnt != TMR_W'(CMD_TIMEOUT))
				cnt <= cnt + 1'b1;	// parks at CMD_TIMEOUT
		end
	end

	// transvld is cleared only on the edge after the pulse
	a_timeout_run: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		timeout |-> run)
		else $error("watchdog fired with no transaction open");

endmodule

/* source/flush_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// command tracking fsm, flushes the buffers when a command ends
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module flush_ctrl
	import spisreg_pkg::*;
(
	input  logic  s_avmm_clk,
	input  logic  s_avmm_rst_n,
	input  data_t s_cmd,
	input  logic  avmmtransvld_up,
	input  logic  ssn_off,
	buf_if.mon    wbuf,
	buf_if.mon    rbuf,
	output logic  wbuf_flush,
	output logic  rbuf_flush
);

	typedef enum logic [1:0] {IDLE, CMD_WR, CMD_RD} state_t;

	state_t state;
	state_t state_nxt;
	logic   wempty_d;
	logic   wempty_rise;	// write buffer just drained

	assign wempty_rise = wbuf.empty & ~wempty_d;

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			state    <= IDLE;
			wempty_d <= 1'b1;	// buffer is empty out of reset
		end else begin
			state    <= state_nxt;
			wempty_d <= wbuf.empty;
		end
	end

	always_comb begin
		state_nxt  = state;
		wbuf_flush = 1'b0;
		rbuf_flush = 1'b0;
		case (state)
			IDLE: begin
				if (s_cmd[CMD_TRANSVLD])
					state_nxt = s_cmd[CMD_RDNWR] ? CMD_RD : CMD_WR;
			end
			CMD_WR: begin
				rbuf_flush = wempty_rise;
				// a timed-out write drops transvld without avmmtransvld_up
				if (avmmtransvld_up || !s_cmd[CMD_TRANSVLD])
					state_nxt = IDLE;
			end
			CMD_RD: begin
				if (ssn_off) begin
					wbuf_flush = 1'b1;
					rbuf_flush = 1'b1;
					state_nxt  = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	a_no_idle_flush: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		(state == IDLE) |-> !(wbuf.flush || rbuf.flush))
		else $error("buffer flush seen with no command open");

endmodule

/* source/spis_reg.sv */
////////////////////////////////////////////////////////////////////////////
// s_cmd, s_status, s_diag0/1 and the registered spi read mux
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spis_reg
	import spisreg_pkg::*;
(
	input  logic  s_avmm_clk,
	input  logic  s_avmm_rst_n,
	input  logic  wr,
	input  logic  rd,
	input  addr_t addr,
	input  data_t wdata,
	output data_t rdata,
	input  logic  avmmtransvld_up,
	input  logic  timeout,
	input  logic  ssn_off,
	input  data_t dbg_bus0,
	input  data_t dbg_bus1,
	buf_if.mon    wbuf,
	buf_if.mon    rbuf,
	output data_t s_cmd
);

	data_t s_status;
	data_t s_diag0;
	data_t s_diag1;
	logic  timeout_st;

	//////////////////////////////////////////////////////////////////////////
	// command register
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			s_cmd <= '0;
		else if (wr && addr == REG_CMD)
			s_cmd <= wdata;	// a new command wins over the clear
		else if (avmmtransvld_up || timeout)
			s_cmd[CMD_TRANSVLD] <= 1'b0;
	end

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			timeout_st <= 1'b0;
		else if (timeout)
			timeout_st <= 1'b1;
	end

	// debug snapshots
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			s_diag0 <= '0;
			s_diag1 <= '0;
		end else begin
			if (ssn_off)
				s_diag0 <= dbg_bus0;	// end of spi frame
			if (avmmtransvld_up)
				s_diag1 <= dbg_bus1;	// end of avmm transaction
		end
	end

	always_comb begin
		s_status                         = '0;
		s_status[ST_WCNT_LO +: CNT_W]    = wbuf.count;
		s_status[ST_RCNT_LO +: CNT_W]    = rbuf.count;
		s_status[ST_WOVF]                = wbuf.overflow;
		s_status[ST_WUDF]                = wbuf.underflow;
		s_status[ST_ROVF]                = rbuf.overflow;
		s_status[ST_RUDF]                = rbuf.underflow;
		s_status[ST_TIMEOUT]             = timeout_st;
	end

	//////////////////////////////////////////////////////////////////////////
	// read mux, unmapped addresses return zero
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			rdata <= '0;
		end else if (rd) begin
			case (addr)
				REG_CMD:    rdata <= s_cmd;
				REG_STATUS: rdata <= s_status;
				REG_DIAG0:  rdata <= s_diag0;
				REG_DIAG1:  rdata <= s_diag1;
				default:    rdata <= '0;
			endcase
		end
	end

endmodule

/* source/spis_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// synchronous fifo with show-ahead head word and fill count
// over/underflow are sticky, flush empties without clearing them
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spis_fifo
	import spisreg_pkg::*;
#(
	parameter type payload_t = data_t,
	parameter int  DEPTH     = BUF_DEPTH	// power of two
) (
	input logic s_avmm_clk,
	input logic s_avmm_rst_n,
	buf_if.fifo bus
);

	localparam int AW = $clog2(DEPTH);

	payload_t    mem [DEPTH];
	logic [AW:0] wptr;	// msb is the wrap bit
	logic [AW:0] rptr;
	logic [AW:0] fill;
	logic        do_push;
	logic        do_pop;
	logic        ovf_q;
	logic        udf_q;

	assign fill    = wptr - rptr;
	assign do_push = bus.push & ~bus.full;	// push on full is dropped
	assign do_pop  = bus.pop & ~bus.empty;

	assign bus.count     = CNT_W'(fill);
	assign bus.full      = (fill == (AW+1)'(DEPTH));
	assign bus.empty     = (fill == '0);
	assign bus.rddata    = mem[rptr[AW-1:0]];
	assign bus.overflow  = ovf_q;
	assign bus.underflow = udf_q;

	always_ff @(posedge s_avmm_clk) begin
		if (do_push && !bus.flush)
			mem[wptr[AW-1:0]] <= bus.wrdata;
	end

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else if (bus.flush) begin
			wptr <= '0;	// flush wins over push and pop
			rptr <= '0;
		end else begin
			if (do_push)
				wptr <= wptr + 1'b1;
			if (do_pop)
				rptr <= rptr + 1'b1;
		end
	end

	// sticky error bits, only reset clears them
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			ovf_q <= 1'b0;
			udf_q <= 1'b0;
		end else begin
			if (bus.push && bus.full)
				ovf_q <= 1'b1;
			if (bus.pop && bus.empty)
				udf_q <= 1'b1;
		end
	end

	a_fill_range: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		fill <= (AW+1)'(DEPTH))
		else $error("fifo fill beyond depth");

	a_flags_excl: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		!(bus.empty && bus.full))
		else $error("fifo empty and full together");

endmodule

/* source/levelsync.sv */
////////////////////////////////////////////////////////////////////////////
// two-flop level synchronizer with rising edge pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module levelsync (
	input  logic s_avmm_clk,
	input  logic s_avmm_rst_n,
	input  logic level,
	output logic synced,
	output logic rise
);

	logic meta;
	logic sync;
	logic sync_d;	// previous synced value

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			meta   <= 1'b0;
			sync   <= 1'b0;
			sync_d <= 1'b0;
		end else begin
			meta   <= level;
			sync   <= meta;
			sync_d <= sync;
		end
	end

	assign synced = sync;
	assign rise   = sync & ~sync_d;	// high for one cycle after the 2nd edge

endmodule

/* source/buf_if.sv */
////////////////////////////////////////////////////////////////////////////
// buffer interface, push/pop side plus flags, fill count and flush
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface buf_if
	import spisreg_pkg::*;
#(
	parameter type payload_t = data_t
) ();

	logic             push;
	logic             pop;
	payload_t         wrdata;
	logic             flush;	// from flush_ctrl
	payload_t         rddata;	// head of the buffer
	logic [CNT_W-1:0] count;
	logic             full;
	logic             empty;
	logic             overflow;	// sticky
	logic             underflow;	// sticky

	modport fifo (input push, pop, wrdata, flush,
		output rddata, count, full, empty, overflow, underflow);

	modport ctrl (output push, pop, wrdata,
		input rddata, full, empty);

	modport mon (input count, full, empty, overflow, underflow, flush);

endinterface

/* source/spisreg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types and constants of the spi slave register block
// address map, s_cmd and s_status bit layout, buffer sizing, watchdog
////////////////////////////////////////////////////////////////////////////
package spisreg_pkg;

	typedef logic [31:0] data_t;	// buffer and register word
	typedef logic [15:0] addr_t;

	// buffer sizing
	localparam int BUF_DEPTH = 64;
	localparam int CNT_W     = $clog2(BUF_DEPTH) + 1;	// holds 0..BUF_DEPTH

	// buffer windows
	localparam addr_t WBUF_LO = 16'h0200;
	localparam addr_t WBUF_HI = 16'h09FF;
	localparam addr_t RBUF_LO = 16'h1000;
	localparam addr_t RBUF_HI = 16'h17FF;

	// register map
	localparam addr_t REG_CMD    = 16'h0000;
	localparam addr_t REG_STATUS = 16'h0004;
	localparam addr_t REG_DIAG0  = 16'h0008;
	localparam addr_t REG_DIAG1  = 16'h000C;

	// s_cmd fields
	localparam int CMD_BRST_HI  = 31;
	localparam int CMD_BRST_LO  = 24;
	localparam int CMD_SEL_HI   = 20;
	localparam int CMD_SEL_LO   = 19;
	localparam int CMD_OFS_HI   = 18;
	localparam int CMD_OFS_LO   = 2;
	localparam int CMD_RDNWR    = 1;
	localparam int CMD_TRANSVLD = 0;

	// s_status fields
	localparam int ST_WCNT_LO = 0;
	localparam int ST_RCNT_LO = 8;
	localparam int ST_WOVF    = 16;
	localparam int ST_WUDF    = 17;
	localparam int ST_ROVF    = 18;
	localparam int ST_RUDF    = 19;
	localparam int ST_TIMEOUT = 20;

	// watchdog, cycles of an open transaction before it is dropped
	localparam int CMD_TIMEOUT = 256;
	localparam int TMR_W       = 9;

endpackage
